//--- common/cpuPkg.sv
package cpuPkg;

    // RV32I major opcodes
    localparam logic [6:0] opLui = 7'b0110111;
    localparam logic [6:0] opOpImm = 7'b0010011;
    localparam logic [6:0] opOp = 7'b0110011;
    localparam logic [6:0] opLoad = 7'b0000011;
    localparam logic [6:0] opStore = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal = 7'b1101111;
    localparam logic [6:0] opSystem = 7'b1110011;

    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt = 3'b010;
    localparam logic [2:0] f3Xor = 3'b100;
    localparam logic [2:0] f3Or = 3'b110;
    localparam logic [2:0] f3And = 3'b111;
    localparam logic [2:0] f3Beq = 3'b000;
    localparam logic [2:0] f3Bne = 3'b001;
    localparam logic [2:0] f3Word = 3'b010;     // LW and SW only

    localparam logic [6:0] f7Base = 7'b0000000;
    localparam logic [6:0] f7Sub = 7'b0100000;

    localparam int regCount = 32;
    localparam int regAddrWidth = 5;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluEq
    } aluOp;

    typedef struct packed {
        logic [6:0] funct7;
        logic [regAddrWidth-1:0] rs2;
        logic [regAddrWidth-1:0] rs1;
        logic [2:0] funct3;
        logic [regAddrWidth-1:0] rd;
        logic [6:0] opcode;
    } rType;

    typedef struct packed {
        logic [11:0] imm;
        logic [regAddrWidth-1:0] rs1;
        logic [2:0] funct3;
        logic [regAddrWidth-1:0] rd;
        logic [6:0] opcode;
    } iType;

    typedef struct packed {
        logic [6:0] immHi;
        logic [regAddrWidth-1:0] rs2;
        logic [regAddrWidth-1:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sType;

    // Branch offset bits are scattered
    typedef struct packed {
        logic imm12;
        logic [5:0] imm10to5;
        logic [regAddrWidth-1:0] rs2;
        logic [regAddrWidth-1:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic imm11;
        logic [6:0] opcode;
    } bType;

    typedef struct packed {
        logic [19:0] imm;
        logic [regAddrWidth-1:0] rd;
        logic [6:0] opcode;
    } uType;

    typedef struct packed {
        logic imm20;
        logic [9:0] imm10to1;
        logic imm11;
        logic [7:0] imm19to12;
        logic [regAddrWidth-1:0] rd;
        logic [6:0] opcode;
    } jType;

    typedef union packed {
        logic [31:0] word;
        rType r;
        iType i;
        sType s;
        bType b;
        uType u;
        jType j;
    } instrWord;

endpackage

//--- common/memBus.sv
`timescale 1ns/1ps

interface memBus;
    import memMapPkg::*;

    logic read;
    logic write;
    logic [addrWidth-1:0] addr;
    logic [dataWidth-1:0] wdata;
    logic [dataWidth-1:0] rdata;
    logic ready;      // Read data valid
    logic written;    // Write done

    modport initiator (
        output read, write, addr, wdata,
        input rdata, ready, written
    );

    modport target (
        input read, write, addr, wdata,
        output rdata, ready, written
    );

endinterface

//--- common/memMapPkg.sv
package memMapPkg;

    localparam int addrWidth = 32;
    localparam int dataWidth = 32;

    // Depth of each RAM in words
    localparam int ramWords = 256;
    localparam int ramIndexWidth = $clog2(ramWords);

    localparam int ioSelectBit = 31;     // Set means LED register

    typedef logic [7:0] ledByte;

endpackage

//--- cpu/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
    input cpuPkg::aluOp op,
    input logic [memMapPkg::dataWidth-1:0] a,
    input logic [memMapPkg::dataWidth-1:0] b,
    output logic [memMapPkg::dataWidth-1:0] result,
    output logic equal
);
    import cpuPkg::*;
    import memMapPkg::*;

    logic lessThan;

    assign equal = (a == b);               // BEQ and BNE
    assign lessThan = ($signed(a) < $signed(b));

    always_comb begin
        unique case (op)
            aluAdd: result = a + b;
            aluSub: result = a - b;
            aluAnd: result = a & b;
            aluOr: result = a | b;
            aluXor: result = a ^ b;
            aluSlt: result = {{(dataWidth-1){1'b0}}, lessThan};
            aluEq: result = {{(dataWidth-1){1'b0}}, equal};
            default: result = '0;
        endcase
    end

endmodule

//--- cpu/cpuCore.sv
`timescale 1ns/1ps

module cpuCore (
    input logic Clock,
    input logic rst,
    memBus.initiator instrBus,
    memBus.initiator dataBus,
    output logic halted
);
    import cpuPkg::*;
    import memMapPkg::*;

    typedef enum logic [2:0] {
        sFetch,
        sFetchWait,
        sExecute,
        sMem,
        sMemWait,
        sWriteback,
        sHalt
    } coreState;

    coreState state;
    instrWord instr;
    logic [addrWidth-1:0] pc;
    logic [addrWidth-1:0] pcPlus4;
    logic [addrWidth-1:0] nextPc;
    logic [dataWidth-1:0] rs1Data;
    logic [dataWidth-1:0] rs2Data;
    logic [dataWidth-1:0] imm;
    logic [dataWidth-1:0] aluA;
    logic [dataWidth-1:0] aluB;
    logic [dataWidth-1:0] aluResult;
    logic [dataWidth-1:0] aluResultQ;
    logic [dataWidth-1:0] loadDataQ;
    logic [dataWidth-1:0] writeData;
    aluOp op;
    logic equal;
    logic useImm;
    logic writesRd;
    logic isLoad;
    logic isStore;
    logic isBranch;
    logic isJal;
    logic stop;
    logic taken;

    always_comb begin
        op = aluAdd;
        useImm = 1'b1;
        writesRd = 1'b0;
        isLoad = 1'b0;
        isStore = 1'b0;
        isBranch = 1'b0;
        isJal = 1'b0;
        stop = 1'b0;
        unique case (instr.r.opcode)
            opLui: writesRd = 1'b1;
            opOp, opOpImm: begin
                writesRd = 1'b1;
                useImm = (instr.r.opcode == opOpImm);
                unique case (instr.r.funct3)
                    f3AddSub: begin
                        if (instr.r.opcode == opOp && instr.r.funct7 == f7Sub) begin
                            op = aluSub;
                        end
                    end
                    f3Slt: op = aluSlt;
                    f3Xor: op = aluXor;
                    f3Or: op = aluOr;
                    f3And: op = aluAnd;
                    default: stop = 1'b1;
                endcase
                // Only SUB may carry a nonzero funct7
                if (instr.r.opcode == opOp && instr.r.funct7 != f7Base &&
                    !(instr.r.funct7 == f7Sub && instr.r.funct3 == f3AddSub)) begin
                    stop = 1'b1;
                end
            end
            opLoad: begin
                writesRd = 1'b1;
                isLoad = 1'b1;
                stop = (instr.i.funct3 != f3Word);
            end
            opStore: begin
                isStore = 1'b1;
                stop = (instr.s.funct3 != f3Word);
            end
            opBranch: begin
                useImm = 1'b0;
                isBranch = 1'b1;
                op = aluEq;
                stop = (instr.b.funct3 != f3Beq) && (instr.b.funct3 != f3Bne);
            end
            opJal: begin
                writesRd = 1'b1;
                isJal = 1'b1;
            end
            opSystem: stop = 1'b1;    // ECALL
            default: stop = 1'b1;
        endcase
    end

    always_comb begin
        unique case (instr.r.opcode)
            opStore: imm = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
            opBranch: imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                             instr.b.imm10to5, instr.b.imm4to1, 1'b0};
            opLui: imm = {instr.u.imm, 12'b0};
            opJal: imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19to12,
                          instr.j.imm11, instr.j.imm10to1, 1'b0};
            default: imm = {{20{instr.i.imm[11]}}, instr.i.imm};
        endcase
    end

    assign aluA = (instr.r.opcode == opLui) ? '0 : rs1Data;   // LUI is 0 + imm
    assign aluB = useImm ? imm : rs2Data;

    assign taken = isBranch && ((instr.b.funct3 == f3Bne) ? !equal : equal);
    assign pcPlus4 = pc + addrWidth'(4);
    assign nextPc = (isJal || taken) ? pc + imm : pcPlus4;

    // JAL links the return address
    assign writeData = isLoad ? loadDataQ : (isJal ? pcPlus4 : aluResultQ);

    assign instrBus.read = (state == sFetch);
    assign instrBus.write = 1'b0;
    assign instrBus.addr = pc;
    assign instrBus.wdata = '0;

    assign dataBus.read = (state == sMem) && isLoad;
    assign dataBus.write = (state == sMem) && isStore;
    assign dataBus.addr = aluResultQ;
    assign dataBus.wdata = rs2Data;

    assign halted = (state == sHalt);

    always_ff @(posedge Clock) begin
        if (rst) begin
            state <= sFetch;
            pc <= '0;
        end else begin
            unique case (state)
                sFetch: state <= sFetchWait;
                sFetchWait: if (instrBus.ready) state <= sExecute;
                sExecute: begin
                    if (stop) begin
                        state <= sHalt;
                    end else if (isLoad || isStore) begin
                        state <= sMem;
                    end else begin
                        state <= sWriteback;
                    end
                end
                sMem: state <= sMemWait;
                sMemWait: if (dataBus.ready || dataBus.written) state <= sWriteback;
                sWriteback: begin
                    pc <= nextPc;
                    state <= sFetch;
                end
                default: state <= sHalt;    // Stays halted until reset
            endcase
        end
    end

    always_ff @(posedge Clock) begin
        if (state == sFetchWait && instrBus.ready) instr <= instrBus.rdata;
        if (state == sExecute) aluResultQ <= aluResult;
        if (state == sMemWait && dataBus.ready) loadDataQ <= dataBus.rdata;
    end

    aluUnit alu (
        .op(op),
        .a(aluA),
        .b(aluB),
        .result(aluResult),
        .equal(equal)
    );

    regFile regs (
        .Clock(Clock),
        .rst(rst),
        .readAddrA(instr.r.rs1),
        .readAddrB(instr.r.rs2),
        .readDataA(rs1Data),
        .readDataB(rs2Data),
        .writeEn((state == sWriteback) && writesRd),
        .writeAddr(instr.r.rd),
        .writeData(writeData)
    );

    // Branch and JAL targets must keep fetches word aligned
    pcAligned: assert property (@(posedge Clock) disable iff (rst) pc[1:0] == 2'b00)
        else $error("pc not word aligned: %h", pc);

endmodule

//--- cpu/regFile.sv
`timescale 1ns/1ps

module regFile (
    input logic Clock,
    input logic rst,
    input logic [cpuPkg::regAddrWidth-1:0] readAddrA,
    input logic [cpuPkg::regAddrWidth-1:0] readAddrB,
    output logic [memMapPkg::dataWidth-1:0] readDataA,
    output logic [memMapPkg::dataWidth-1:0] readDataB,
    input logic writeEn,
    input logic [cpuPkg::regAddrWidth-1:0] writeAddr,
    input logic [memMapPkg::dataWidth-1:0] writeData
);
    import cpuPkg::*;
    import memMapPkg::*;

    logic [dataWidth-1:0] regs [regCount];

    always_ff @(posedge Clock) begin
        if (rst) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;   // x0 stays zero
        end
    end

    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

endmodule

//--- cpuSystem.f
common/memMapPkg.sv
common/cpuPkg.sv
common/memBus.sv
cpu/aluUnit.sv
cpu/regFile.sv
cpu/cpuCore.sv
verilog/syncRam.sv
verilog/ioDecoder.sv
verilog/cpuSystem.sv
tb/clockGen.sv
tb/cpuSystemTb.sv

//--- tb/clockGen.sv
`timescale 1ns/1ps

module clockGen (
    output logic Clock
);
    localparam int halfPeriod = 50;    // 100 ns period

    initial begin
        Clock = 1'b0;
        forever begin
            #halfPeriod Clock = ~Clock;
        end
    end

endmodule

//--- tb/cpuSystemTb.sv
`timescale 1ns/1ps

module cpuSystemTb;
    import cpuPkg::*;
    import memMapPkg::*;

    typedef enum int {
        kindEcall, kindAdd, kindSub, kindAnd, kindOr, kindXor, kindSlt, kindAddi,
        kindMem, kindLoop, kindLedRead, kindZeroReg
    } testKind;

    localparam int numTests = 12;
    localparam int clockPeriod = 100;
    localparam logic [31:0] ecallWord = 32'h00000073;

    logic Clock;
    logic rst;
    logic loadEn;
    logic [ramIndexWidth-1:0] loadAddr;
    logic [dataWidth-1:0] loadData;
    ledByte led;
    logic halted;

    logic [31:0] prog [$];
    integer seed;
    int errorCount;
    ledByte expLed;
    logic expHalted;
    logic checkPending;

    clockGen clocks (.Clock(Clock));

    cpuSystem i_cpuSystem (
        .Clock(Clock),
        .rst(rst),
        .loadEn(loadEn),
        .loadAddr(loadAddr),
        .loadData(loadData),
        .led(led),
        .halted(halted)
    );

    function automatic logic [31:0] aluInstr(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, opOp};
    endfunction

    function automatic logic [31:0] immInstr(input logic [6:0] opc, input logic [2:0] f3,
                                             input logic [4:0] rd, rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] storeInstr(input logic [4:0] rs2, rs1,
                                               input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3Word, imm[4:0], opStore};
    endfunction

    function automatic logic [31:0] branchInstr(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                                input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opBranch};
    endfunction

    function automatic logic [31:0] luiInstr(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, opLui};
    endfunction

    function automatic logic [31:0] jalInstr(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, opJal};
    endfunction

    // LUI then ADDI with the upper part rounded for the sign of the low 12 bits
    task automatic setRegister(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] rounded;
        rounded = value + 32'h800;
        prog.push_back(luiInstr(rd, rounded[31:12]));
        prog.push_back(immInstr(opOpImm, f3AddSub, rd, rd, value[11:0]));
    endtask

    task automatic buildProgram(input testKind kind, input logic [31:0] a, input logic [31:0] b);
        prog.delete();
        if (kind != kindEcall) prog.push_back(luiInstr(5'd31, 20'h80000));   // x31 = LED
        case (kind)
            kindAdd, kindSub, kindAnd, kindOr, kindXor, kindSlt, kindAddi: begin
                setRegister(5'd1, a);
                setRegister(5'd2, b);
                case (kind)
                    kindAdd: prog.push_back(aluInstr(f7Base, f3AddSub, 5'd3, 5'd1, 5'd2));
                    kindSub: prog.push_back(aluInstr(f7Sub, f3AddSub, 5'd3, 5'd1, 5'd2));
                    kindAnd: prog.push_back(aluInstr(f7Base, f3And, 5'd3, 5'd1, 5'd2));
                    kindOr: prog.push_back(aluInstr(f7Base, f3Or, 5'd3, 5'd1, 5'd2));
                    kindXor: prog.push_back(aluInstr(f7Base, f3Xor, 5'd3, 5'd1, 5'd2));
                    kindSlt: prog.push_back(aluInstr(f7Base, f3Slt, 5'd3, 5'd1, 5'd2));
                    default: prog.push_back(immInstr(opOpImm, f3AddSub, 5'd3, 5'd1, b[11:0]));
                endcase
                prog.push_back(storeInstr(5'd3, 5'd31, 12'd0));
            end
            kindMem: begin
                setRegister(5'd1, a);
                prog.push_back(immInstr(opOpImm, f3AddSub, 5'd5, 5'd0, 12'h100));
                prog.push_back(storeInstr(5'd1, 5'd5, 12'd0));
                prog.push_back(immInstr(opOpImm, f3AddSub, 5'd1, 5'd0, 12'hfff));  // clobber
                prog.push_back(immInstr(opLoad, f3Word, 5'd4, 5'd5, 12'd0));
                prog.push_back(storeInstr(5'd4, 5'd31, 12'd0));
            end
            kindLoop: begin
                prog.push_back(immInstr(opOpImm, f3AddSub, 5'd1, 5'd0, 12'd0));
                prog.push_back(immInstr(opOpImm, f3AddSub, 5'd2, 5'd0, a[11:0]));
                prog.push_back(immInstr(opOpImm, f3AddSub, 5'd3, 5'd0, b[11:0]));
                prog.push_back(aluInstr(f7Base, f3AddSub, 5'd1, 5'd1, 5'd3));
                prog.push_back(immInstr(opOpImm, f3AddSub, 5'd2, 5'd2, 12'hfff));
                prog.push_back(branchInstr(f3Bne, 5'd2, 5'd0, 13'h1ff8));   // back to ADD
                prog.push_back(branchInstr(f3Beq, 5'd1, 5'd0, 13'd12));     // never taken
                prog.push_back(storeInstr(5'd1, 5'd31, 12'd0));
                prog.push_back(jalInstr(5'd0, 21'd8));
                prog.push_back(storeInstr(5'd0, 5'd31, 12'd0));             // poison
            end
            kindLedRead: begin
                prog.push_back(immInstr(opOpImm, f3AddSub, 5'd1, 5'd0, {4'b0, a[7:0]}));
                prog.push_back(storeInstr(5'd1, 5'd31, 12'd0));
                prog.push_back(immInstr(opLoad, f3Word, 5'd2, 5'd31, 12'd0));
                prog.push_back(immInstr(opOpImm, f3AddSub, 5'd2, 5'd2, 12'd1));
                prog.push_back(storeInstr(5'd2, 5'd31, 12'd0));
            end
            kindZeroReg: begin
                prog.push_back(immInstr(opOpImm, f3AddSub, 5'd1, 5'd0, 12'h03c));
                prog.push_back(storeInstr(5'd1, 5'd31, 12'd0));
                prog.push_back(immInstr(opOpImm, f3AddSub, 5'd0, 5'd0, 12'h05a));
                prog.push_back(aluInstr(f7Base, f3AddSub, 5'd0, 5'd1, 5'd1));
                prog.push_back(storeInstr(5'd0, 5'd31, 12'd0));
            end
            default: ;
        endcase
        prog.push_back(ecallWord);
    endtask

    // Expected LED byte for each kind of program
    function automatic ledByte refLed(input testKind kind, input logic [31:0] a,
                                      input logic [31:0] b);
        logic [31:0] r;
        case (kind)
            kindAdd: r = a + b;
            kindSub: r = a - b;
            kindAnd: r = a & b;
            kindOr: r = a | b;
            kindXor: r = a ^ b;
            kindSlt: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            kindAddi: r = a + {{20{b[11]}}, b[11:0]};
            kindMem: r = a;
            kindLoop: r = a * b;
            kindLedRead: r = {24'b0, a[7:0]} + 32'd1;
            default: r = '0;
        endcase
        return r[7:0];
    endfunction

    task automatic checkLed(input ledByte expected, input ledByte actual);
        if (actual !== expected) begin
            errorCount++;
            $display("ERR led expected %h actual %h", expected, actual);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic checkHalted(input logic expected, input logic actual);
        if (actual !== expected) begin
            errorCount++;
            $display("ERR halted expected %h actual %h", expected, actual);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic requestCheck(input ledByte ledValue, input logic haltedValue);
        expLed = ledValue;
        expHalted = haltedValue;
        checkPending = 1'b1;
        wait (checkPending == 1'b0);
        @(posedge Clock);
        #1;
    endtask

    task automatic runTest(input testKind kind, input logic [31:0] a, input logic [31:0] b);
        buildProgram(kind, a, b);
        loadEn = 1'b1;
        foreach (prog[i]) begin
            loadAddr = ramIndexWidth'(i);
            loadData = prog[i];
            @(posedge Clock);
            #1;
        end
        loadEn = 1'b0;
        requestCheck(expLed, 1'b0);    // Core restarts, LED keeps its value
        while (halted !== 1'b1) begin
            @(posedge Clock);
            #1;
        end
        @(posedge Clock);    // Halted must hold
        #1;
        requestCheck(refLed(kind, a, b), 1'b1);
    endtask

    // Outputs are settled by the falling edge
    always @(negedge Clock) begin
        if (checkPending) begin
            checkLed(expLed, led);
            checkHalted(expHalted, halted);
            checkPending = 1'b0;
        end
    end

    initial begin
        #(numTests * 2000 * clockPeriod);
        $display("Timeout: a program never halted within the watchdog limit");
        $display("Finished with errors");
        $fatal(1);
    end

    initial begin
        logic [31:0] n;
        logic [31:0] k;
        seed = 26098;
        errorCount = 0;
        rst = 1'b1;
        loadEn = 1'b0;
        loadAddr = '0;
        loadData = '0;
        checkPending = 1'b0;
        expLed = '0;
        expHalted = 1'b0;
        repeat (4) @(posedge Clock);
        #1;
        rst = 1'b0;
        loadEn = 1'b1;    // core idle until the first program
        requestCheck(8'h00, 1'b0);

        runTest(kindEcall, 32'd0, 32'd0);
        for (int t = int'(kindAdd); t <= int'(kindAddi); t++) begin
            runTest(testKind'(t), $random(seed), $random(seed));
        end
        runTest(kindMem, $random(seed), 32'd0);
        n = 1 + ({$random(seed)} % 20);
        k = 1 + ({$random(seed)} % 15);
        runTest(kindLoop, n, k);
        runTest(kindLedRead, $random(seed), 32'd0);
        runTest(kindZeroReg, 32'd0, 32'd0);

        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- verilog/cpuSystem.sv
`timescale 1ns/1ps

module cpuSystem (
    input logic Clock,
    input logic rst,
    input logic loadEn,
    input logic [memMapPkg::ramIndexWidth-1:0] loadAddr,
    input logic [memMapPkg::dataWidth-1:0] loadData,
    output memMapPkg::ledByte led,
    output logic halted
);
    import memMapPkg::*;

    logic coreRst;

    memBus coreInstrBus ();
    memBus instrBus ();
    memBus dataBus ();
    memBus ramBus ();

    assign coreRst = rst || loadEn;    // Core waits while a program is loaded

    // Load port takes over the instruction RAM
    assign instrBus.read = loadEn ? 1'b0 : coreInstrBus.read;
    assign instrBus.write = loadEn ? 1'b1 : coreInstrBus.write;
    assign instrBus.addr = loadEn ? {{(addrWidth-ramIndexWidth-2){1'b0}}, loadAddr, 2'b00}
                                  : coreInstrBus.addr;
    assign instrBus.wdata = loadEn ? loadData : coreInstrBus.wdata;

    assign coreInstrBus.rdata = instrBus.rdata;
    assign coreInstrBus.ready = instrBus.ready;
    assign coreInstrBus.written = instrBus.written;

    cpuCore core (
        .Clock(Clock),
        .rst(coreRst),
        .instrBus(coreInstrBus),
        .dataBus(dataBus),
        .halted(halted)
    );

    syncRam instrRam (
        .Clock(Clock),
        .rst(rst),
        .bus(instrBus)
    );

    ioDecoder decoder (
        .Clock(Clock),
        .rst(rst),
        .cpuSide(dataBus),
        .ramSide(ramBus),
        .led(led)
    );

    syncRam dataRam (
        .Clock(Clock),
        .rst(rst),
        .bus(ramBus)
    );

endmodule

//--- verilog/ioDecoder.sv
`timescale 1ns/1ps

module ioDecoder (
    input logic Clock,
    input logic rst,
    memBus.target cpuSide,
    memBus.initiator ramSide,
    output memMapPkg::ledByte led
);
    import memMapPkg::*;

    logic ioSelect;
    logic ledReadPending;
    logic ledWritePending;

    assign ioSelect = cpuSide.addr[ioSelectBit];

    // RAM traffic passes straight through
    assign ramSide.read = cpuSide.read && !ioSelect;
    assign ramSide.write = cpuSide.write && !ioSelect;
    assign ramSide.addr = cpuSide.addr;
    assign ramSide.wdata = cpuSide.wdata;

    always_ff @(posedge Clock) begin
        if (rst) begin
            led <= '0;
            ledReadPending <= 1'b0;
            ledWritePending <= 1'b0;
        end else begin
            ledReadPending <= cpuSide.read && ioSelect;
            ledWritePending <= cpuSide.write && ioSelect;
            if (cpuSide.write && ioSelect) led <= cpuSide.wdata[$bits(ledByte)-1:0];
        end
    end

    assign cpuSide.ready = ramSide.ready || ledReadPending;
    assign cpuSide.written = ramSide.written || ledWritePending;
    assign cpuSide.rdata = ledReadPending ? {{(dataWidth-$bits(ledByte)){1'b0}}, led}
                                          : ramSide.rdata;

    // Core must wait for the LED answer
    noOverlap: assert property (@(posedge Clock) disable iff (rst)
        (ledReadPending || ledWritePending) |-> !(cpuSide.read || cpuSide.write))
        else $error("new request while LED answer pending");

endmodule

//--- verilog/syncRam.sv
`timescale 1ns/1ps

module syncRam (
    input logic Clock,
    input logic rst,
    memBus.target bus
);
    import memMapPkg::*;

    logic [dataWidth-1:0] mem [ramWords];
    logic [ramIndexWidth-1:0] index;

    // Word index from byte address
    assign index = bus.addr[ramIndexWidth+1:2];

    always_ff @(posedge Clock) begin
        if (bus.write) mem[index] <= bus.wdata;
        if (bus.read) bus.rdata <= mem[index];
    end

    // Answer one cycle after the request
    always_ff @(posedge Clock) begin
        if (rst) begin
            bus.ready <= 1'b0;
            bus.written <= 1'b0;
        end else begin
            bus.ready <= bus.read;
            bus.written <= bus.write;
        end
    end

    noReadWrite: assert property (@(posedge Clock) disable iff (rst) !(bus.read && bus.write))
        else $error("read and write requested together at %h", bus.addr);

endmodule
